// File: logic/uart_cmd_pkg.sv
package uart_cmd_pkg;

  localparam int BIT_CYCLES = 434;              // 50 MHz clock at 115200 baud.
  localparam int HALF_BIT   = 217;              // Receiver sample point.
  localparam int GAP_CYCLES = 100;              // Idle gap between frames.
  localparam int BAUD_W     = $clog2(BIT_CYCLES);
  localparam int GAP_W      = $clog2(GAP_CYCLES);

  // Frame bit positions, counted from the start bit.
  localparam logic [3:0] PAR_IDX  = 4'd9;
  localparam logic [3:0] STOP_IDX = 4'd10;

  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_FRAME = 2'd1;
  localparam logic [1:0] RX_ACK   = 2'd2;

  localparam logic [2:0] SEQ_IDLE   = 3'd0;
  localparam logic [2:0] SEQ_TX     = 3'd1;
  localparam logic [2:0] SEQ_TX_REL = 3'd2;
  localparam logic [2:0] SEQ_GAP    = 3'd3;
  localparam logic [2:0] SEQ_RX     = 3'd4;
  localparam logic [2:0] SEQ_RX_REL = 3'd5;
  localparam logic [2:0] SEQ_DONE   = 3'd6;

  typedef struct packed {
    logic       rw;                             // 1 is write.
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_fields_t;

  typedef struct packed {
    logic [7:0] hi;                             // First byte on the line.
    logic [7:0] lo;
  } cmd_bytes_t;

  typedef union packed {
    cmd_fields_t fields;
    cmd_bytes_t  bytes;
  } cmd_word_t;

  typedef struct packed {
    logic parity;
    logic framing;                              // Stop bit sampled low.
  } rx_err_t;

endpackage

// File: logic/rx_chan_if.sv
`timescale 1ns/1ps

interface rx_chan_if
  import uart_cmd_pkg::*;
();

  logic       req;                              // Arms the receiver.
  logic       ack;
  logic [7:0] data;
  rx_err_t    err;

  modport seq (
    output req,
    input  ack,
    input  data,
    input  err
  );

  modport rx (
    input  req,
    output ack,
    output data,
    output err
  );

endinterface

// File: logic/uart_tx_frame.sv
`timescale 1ns/1ps

module uart_tx_frame
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_req,
  input  logic [7:0] tx_byte,
  output logic       tx_ack,
  output logic       tx
);

  logic              busy;
  logic [BAUD_W-1:0] baud_cnt;
  logic [3:0]        bit_cnt;
  logic [9:0]        frame_q;
  logic              bit_end;
  logic              start;

  assign bit_end = (baud_cnt == BAUD_W'(BIT_CYCLES - 1));
  assign start   = !busy && !tx_ack && tx_req;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      tx_ack   <= 1'b0;
      tx       <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (busy)
    begin
      if (bit_end)
      begin
        baud_cnt <= '0;
        if (bit_cnt == STOP_IDX)
        begin
          busy   <= 1'b0;
          tx_ack <= 1'b1;                       // End of the stop bit.
        end
        else
        begin
          bit_cnt <= bit_cnt + 4'd1;
          tx      <= frame_q[0];
        end
      end
      else
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
    else if (tx_ack)
    begin
      if (!tx_req)
        tx_ack <= 1'b0;
    end
    else if (start)
    begin
      busy     <= 1'b1;
      tx       <= 1'b0;                         // Start bit.
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
  end

  // Data LSB first, then odd parity, then the stop bit.
  always_ff @(posedge clk)
  begin
    if (start)
      frame_q <= {1'b1, ~^tx_byte, tx_byte};
    else if (busy && bit_end)
      frame_q <= {1'b1, frame_q[9:1]};
  end

  a_idle_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    !busy |-> tx
  );

endmodule

// File: logic/uart_rx_frame.sv
`timescale 1ns/1ps

module uart_rx_frame
  import uart_cmd_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  rx,
  rx_chan_if.rx chan
);

  logic              rx_s1;
  logic              rx_s2;
  logic              rx_s3;
  logic              fall;
  logic [1:0]        state;
  logic [BAUD_W-1:0] baud_cnt;
  logic [3:0]        bit_cnt;
  logic [7:0]        shift_q;
  logic              par_q;
  logic              mid_bit;
  logic              bit_end;

  assign fall    = rx_s3 && !rx_s2;
  assign mid_bit = (baud_cnt == BAUD_W'(HALF_BIT));
  assign bit_end = (baud_cnt == BAUD_W'(BIT_CYCLES - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_s3 <= 1'b1;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_s3 <= rx_s2;                           // Edge detect delay.
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      chan.ack <= 1'b0;
    end
    else
    begin
      case (state)
        RX_IDLE:
        begin
          if (chan.req && fall)
          begin
            state    <= RX_FRAME;
            baud_cnt <= '0;
            bit_cnt  <= '0;
          end
        end
        RX_FRAME:
        begin
          if (bit_end)
          begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 4'd1;
          end
          else
          begin
            baud_cnt <= baud_cnt + 1'b1;
          end
          if (mid_bit)
          begin
            if (bit_cnt == 4'd0 && rx_s2)
              state <= RX_IDLE;                 // Glitch, not a start bit.
            else if (bit_cnt == STOP_IDX)
            begin
              chan.ack <= 1'b1;
              state    <= RX_ACK;
            end
          end
        end
        RX_ACK:
        begin
          if (!chan.req)
          begin
            chan.ack <= 1'b0;
            state    <= RX_IDLE;
          end
        end
        default:
          state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == RX_FRAME && mid_bit)
    begin
      if (bit_cnt != 4'd0 && bit_cnt < PAR_IDX)
        shift_q <= {rx_s2, shift_q[7:1]};       // LSB arrives first.
      else if (bit_cnt == PAR_IDX)
        par_q <= rx_s2;
      else if (bit_cnt == STOP_IDX)
      begin
        chan.data        <= shift_q;
        chan.err.parity  <= ~^{shift_q, par_q};
        chan.err.framing <= ~rx_s2;
      end
    end
  end

  // The sequencer keeps req up until the frame is handed over.
  a_ack_armed: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(chan.ack) |-> chan.req
  );

endmodule

// File: logic/cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cmd_req,
  input  cmd_word_t  cmd,
  output logic       cmd_ack,
  output logic [7:0] rd_data,
  output rx_err_t    rd_err,
  output logic       tx_req,
  output logic [7:0] tx_byte,
  input  logic       tx_ack,
  rx_chan_if.seq     rx
);

  logic [2:0]       state;
  cmd_word_t        cmd_q;
  logic             lo_phase;
  logic [GAP_W-1:0] gap_cnt;
  logic             gap_end;

  assign gap_end = (gap_cnt == GAP_W'(GAP_CYCLES - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= SEQ_IDLE;
      cmd_ack  <= 1'b0;
      tx_req   <= 1'b0;
      rx.req   <= 1'b0;
      lo_phase <= 1'b0;
      gap_cnt  <= '0;
      rd_data  <= '0;
      rd_err   <= '0;
    end
    else
    begin
      case (state)
        SEQ_IDLE:
        begin
          if (cmd_req)
          begin
            tx_req   <= 1'b1;                   // High byte goes first.
            lo_phase <= 1'b0;
            state    <= SEQ_TX;
          end
        end
        SEQ_TX:
        begin
          if (tx_ack)
          begin
            tx_req <= 1'b0;
            state  <= SEQ_TX_REL;
          end
        end
        SEQ_TX_REL:
        begin
          if (!tx_ack)
          begin
            if (lo_phase)
            begin
              cmd_ack <= 1'b1;                  // Write complete.
              state   <= SEQ_DONE;
            end
            else
            begin
              gap_cnt <= '0;
              state   <= SEQ_GAP;
            end
          end
        end
        SEQ_GAP:
        begin
          if (!gap_end)
            gap_cnt <= gap_cnt + 1'b1;
          else if (cmd_q.fields.rw)
          begin
            lo_phase <= 1'b1;
            tx_req   <= 1'b1;
            state    <= SEQ_TX;
          end
          else
          begin
            rx.req <= 1'b1;                     // Arm for the response.
            state  <= SEQ_RX;
          end
        end
        SEQ_RX:
        begin
          if (rx.ack)
          begin
            rd_data <= rx.data;
            rd_err  <= rx.err;
            rx.req  <= 1'b0;
            state   <= SEQ_RX_REL;
          end
        end
        SEQ_RX_REL:
        begin
          if (!rx.ack)
          begin
            cmd_ack <= 1'b1;
            state   <= SEQ_DONE;
          end
        end
        SEQ_DONE:
        begin
          if (!cmd_req)
          begin
            cmd_ack <= 1'b0;
            state   <= SEQ_IDLE;
          end
        end
        default:
          state <= SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == SEQ_IDLE && cmd_req)
    begin
      cmd_q   <= cmd;
      tx_byte <= cmd.bytes.hi;                  // Flag and address.
    end
    else if (state == SEQ_GAP && gap_end && cmd_q.fields.rw)
      tx_byte <= cmd_q.bytes.lo;
  end

  a_ack_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(cmd_ack) |-> cmd_req
  );

  // Line turnaround. Never send and listen at once.
  a_tx_rx_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(tx_req && rx.req)
  );

endmodule

// File: logic/uart_cmd_top.sv
`timescale 1ns/1ps

module uart_cmd_top
  import uart_cmd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       cmd_req,
  input  cmd_word_t  cmd,
  output logic       cmd_ack,
  output logic [7:0] rd_data,
  output rx_err_t    rd_err,
  input  logic       rx,
  output logic       tx
);

  logic       tx_req;
  logic       tx_ack;
  logic [7:0] tx_byte;

  rx_chan_if rx_chan ();

  cmd_sequencer cmd_sequencer_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .cmd_ack (cmd_ack),
    .rd_data (rd_data),
    .rd_err  (rd_err),
    .tx_req  (tx_req),
    .tx_byte (tx_byte),
    .tx_ack  (tx_ack),
    .rx      (rx_chan.seq)
  );

  uart_tx_frame uart_tx_frame_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_req  (tx_req),
    .tx_byte (tx_byte),
    .tx_ack  (tx_ack),
    .tx      (tx)
  );

  uart_rx_frame uart_rx_frame_i (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .chan  (rx_chan.rx)
  );

endmodule

// File: test/tb_uart_cmd.sv
`timescale 1ns/1ps

module tb_uart_cmd
  import uart_cmd_pkg::*;
();

  localparam int FRAME_CYCLES   = 11 * BIT_CYCLES;
  localparam int TIMEOUT_CYCLES = 40 * FRAME_CYCLES;  // About twice the whole test run.

  logic       clk;
  logic       rst_n;
  logic       cmd_req;
  cmd_word_t  cmd;
  logic       cmd_ack;
  logic [7:0] rd_data;
  rx_err_t    rd_err;
  logic       rx;
  logic       tx;
  int         seed;
  int         cycle_count;
  logic [7:0] last_rd;                          // Byte answered on the last read.

  uart_cmd_top uart_cmd_top_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_req (cmd_req),
    .cmd     (cmd),
    .cmd_ack (cmd_ack),
    .rd_data (rd_data),
    .rd_err  (rd_err),
    .rx      (rx),
    .tx      (tx)
  );

  always #50 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES)
      abort_run($sformatf("Timeout after %0d cycles with a transaction still open.", cycle_count));
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "Simulation stopped on error.");
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
      abort_run($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
  endtask

  task automatic check_err(input string name, input rx_err_t exp, input rx_err_t act);
    if (act !== exp)
      abort_run($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      abort_run($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
  endtask

  function automatic cmd_word_t make_cmd(input logic rw, input logic [6:0] addr,
                                         input logic [7:0] data);
    cmd_word_t c;
    c.fields.rw   = rw;
    c.fields.addr = addr;
    c.fields.data = data;
    return c;
  endfunction

  function automatic rx_err_t err_flags(input logic parity, input logic framing);
    rx_err_t e;
    e.parity  = parity;
    e.framing = framing;
    return e;
  endfunction

  // Line model. Each bit must hold for BIT_CYCLES and is read at HALF_BIT.
  task automatic expect_tx_frame(input logic [7:0] exp, output int first_cyc,
                                 output int last_cyc);
    logic [10:0] bits;
    logic        lvl;
    int          n;
    n = 0;
    @(negedge clk);
    while (tx !== 1'b0)
    begin
      n++;
      if (n > 4 * GAP_CYCLES)
        abort_run("No frame started on tx when one was due.");
      @(negedge clk);
    end
    first_cyc = cycle_count;
    for (int k = 0; k < 11; k++)
    begin
      for (int c = 0; c < BIT_CYCLES; c++)
      begin
        if (k != 0 || c != 0)
          @(negedge clk);
        if (c == 0)
          lvl = tx;
        else if (tx !== lvl)
          abort_run($sformatf("Bit %0d of a tx frame was shorter than a bit period.", k));
        if (c == HALF_BIT)
          bits[k] = tx;
      end
    end
    last_cyc = cycle_count;
    check_byte("tx data", exp, bits[8:1]);
    check_bit("tx parity", 1'b1, ^bits[9:1]);   // Odd count of ones.
    check_bit("tx stop", 1'b1, bits[10]);
    check_bit("cmd_ack", 1'b0, cmd_ack);          // Not before the stop bit ends.
  endtask

  task automatic send_frame(input logic [7:0] data, input logic good_par, input logic stop);
    logic [10:0] bits;
    bits = {stop, good_par ? ~^data : ^data, data, 1'b0};
    for (int k = 0; k < 11; k++)
    begin
      @(posedge clk);
      #5;
      rx = bits[k];
      repeat (BIT_CYCLES - 1) @(posedge clk);
    end
    @(posedge clk);
    #5;
    rx = 1'b1;
  endtask

  task automatic wait_cmd_ack(input logic level, input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (cmd_ack !== level)
    begin
      n++;
      if (n > limit)
        abort_run($sformatf("cmd_ack did not go to %0b within %0d cycles.", level, limit));
      @(negedge clk);
    end
  endtask

  // Host side of the four-phase handshake.
  task automatic finish_cmd();
    @(posedge clk);
    #5;
    cmd_req = 1'b0;
    @(negedge clk);
    check_bit("cmd_ack", 1'b1, cmd_ack);
    wait_cmd_ack(1'b0, 4);
  endtask

  task automatic hold_quiet(input int cycles, input logic ack_level);
    for (int i = 0; i < cycles; i++)
    begin
      @(negedge clk);
      check_bit("tx", 1'b1, tx);
      check_bit("cmd_ack", ack_level, cmd_ack);
    end
  endtask

  task automatic run_write(input logic [6:0] addr, input logic [7:0] data);
    int f1_first;
    int f1_last;
    int f2_first;
    int f2_last;
    @(posedge clk);
    #5;
    cmd     = make_cmd(1'b1, addr, data);
    cmd_req = 1'b1;
    expect_tx_frame({1'b1, addr}, f1_first, f1_last);
    expect_tx_frame(data, f2_first, f2_last);
    if (f2_first - f1_last - 1 < GAP_CYCLES)
      abort_run($sformatf("Gap between write frames was only %0d cycles.",
                          f2_first - f1_last - 1));
    wait_cmd_ack(1'b1, 8);
  endtask

  task automatic run_read(input logic [6:0] addr, input logic good_par, input logic stop);
    logic [31:0] r;
    int          first;
    int          last;
    r = $random(seed);
    last_rd = r[7:0];
    @(posedge clk);
    #5;
    cmd     = make_cmd(1'b0, addr, r[15:8]);
    cmd_req = 1'b1;
    expect_tx_frame({1'b0, addr}, first, last);
    hold_quiet(2 * GAP_CYCLES, 1'b0);           // Receiver arms after the gap.
    send_frame(r[7:0], good_par, stop);
    wait_cmd_ack(1'b1, 8);
    check_byte("rd_data", r[7:0], rd_data);
    check_err("rd_err", err_flags(!good_par, !stop), rd_err);
    finish_cmd();
  endtask

  initial
  begin
    logic [31:0] r;
    clk         = 1'b0;
    rst_n       = 1'b0;
    cmd_req     = 1'b0;
    cmd         = '0;
    rx          = 1'b1;
    seed        = 32'h8aac0c10;
    cycle_count = 0;
    repeat (16) @(posedge clk);
    #5;
    rst_n = 1'b1;
    hold_quiet(4 * BIT_CYCLES, 1'b0);
    r = $random(seed);
    run_write(r[6:0], r[15:8]);
    finish_cmd();
    hold_quiet(2 * BIT_CYCLES, 1'b0);           // No third frame.
    run_read(r[22:16], 1'b1, 1'b1);
    run_read(r[29:23], 1'b0, 1'b1);
    run_read(r[6:0], 1'b1, 1'b0);
    r = $random(seed);
    run_write(r[6:0], r[15:8]);
    hold_quiet(FRAME_CYCLES, 1'b1);             // Held request.
    finish_cmd();
    run_write(r[22:16], r[31:24]);
    finish_cmd();
    check_byte("rd_data", last_rd, rd_data);
    run_read(r[29:23], 1'b1, 1'b1);
    $display("test passed");
    $finish;
  end

endmodule

// File: uart_cmd.f
logic/uart_cmd_pkg.sv
logic/rx_chan_if.sv
logic/uart_tx_frame.sv
logic/uart_rx_frame.sv
logic/cmd_sequencer.sv
logic/uart_cmd_top.sv
test/tb_uart_cmd.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the UART command bridge testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_uart_cmd \
  -f uart_cmd.f -o sim_uart_cmd > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_uart_cmd > sim.log 2>&1
cat sim.log

grep -qx "test passed" sim.log && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }
